// File: rename_cfg.svh
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// Architectural data registers named by the instruction word.
`define NUM_A_REG 8

// Physical register files.
`define NUM_D_REG 16
`define NUM_S_REG 4

// Reorder buffer entries, a power of two.
`define ROB_DEPTH 16

`endif

// File: rename_pkg.sv
`include "rename_cfg.svh"

package rename_pkg;

    // Opcode field of the instruction word, bits 7:6.
    typedef enum logic [1:0] {
        OP_NOP  = 2'b00,
        OP_MOV  = 2'b01,
        OP_CMP  = 2'b10,
        OP_NAND = 2'b11
    } opcode_t;

    // Allocation state of one physical register.
    typedef enum logic {
        REG_IDLE = 1'b0,
        REG_BUSY = 1'b1
    } reg_state_t;

    typedef logic [$clog2(`NUM_D_REG)-1:0] d_addr_t;
    typedef logic [$clog2(`NUM_S_REG)-1:0] s_addr_t;
    typedef logic [2:0]                    a_addr_t;

endpackage

// File: rename_ifc.sv
`timescale 1ns/1ps

// Decoded instruction fields.
interface decoder_ifc
    import rename_pkg::*;
();
    logic    valid;
    opcode_t opcode;
    a_addr_t arch_rw;
    logic    use_rw;
    logic    use_rs;

    modport out (output valid, opcode, arch_rw, use_rw, use_rs);
    modport in  (input  valid, opcode, arch_rw, use_rw, use_rs);
endinterface

// Allocated physical registers and the shared stall.
interface free_reg_list_ifc
    import rename_pkg::*;
();
    d_addr_t rw_addr;
    s_addr_t rs_addr;
    logic    stall;

    modport out (output rw_addr, rs_addr, stall);
    modport in  (input  rw_addr, rs_addr, stall);
endinterface

// Committing instruction, previous mappings go back to the free list.
interface reorder_buffer_ifc
    import rename_pkg::*;
();
    logic    valid;
    logic    use_rw;
    logic    use_rs;
    d_addr_t prev_rw_addr;
    s_addr_t prev_rs_addr;

    modport out (output valid, use_rw, use_rs, prev_rw_addr, prev_rs_addr);
    modport in  (input  valid, use_rw, use_rs, prev_rw_addr, prev_rs_addr);
endinterface

// File: instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
    import rename_pkg::*;
(
    input  logic       instr_valid,
    input  logic [7:0] instr,
    decoder_ifc.out    dec
);

    opcode_t op;

    assign op = opcode_t'(instr[7:6]);

    assign dec.valid   = instr_valid;
    assign dec.opcode  = op;
    assign dec.arch_rw = a_addr_t'(instr[5:3]);

    // Which register classes the instruction writes.
    always_comb begin
        dec.use_rw = 1'b0;
        dec.use_rs = 1'b0;
        case (op)
            OP_MOV: begin
                dec.use_rw = 1'b1;
            end
            OP_CMP: begin
                dec.use_rs = 1'b1;
            end
            OP_NAND: begin
                dec.use_rw = 1'b1;
                dec.use_rs = 1'b1;
            end
            default: begin
                dec.use_rw = 1'b0;
                dec.use_rs = 1'b0;
            end
        endcase
    end

    // Bits 2:0 carry source operands, not renamed here.

endmodule

// File: rename_map.sv
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_map
    import rename_pkg::*;
(
    input  logic           clk,
    input  logic           n_rst,
    decoder_ifc.in         dec,
    free_reg_list_ifc.in   frl,
    output d_addr_t        prev_rw_addr,
    output s_addr_t        prev_rs_addr
);

    d_addr_t d_map [`NUM_A_REG];
    s_addr_t s_map;

    logic accept;
    logic rw_mapped;

    assign accept = dec.valid & ~frl.stall;

    assign prev_rw_addr = d_map[dec.arch_rw];
    assign prev_rs_addr = s_map;

    // Is the new data register already named by some entry.
    always_comb begin
        rw_mapped = 1'b0;
        for (int i = 0; i < `NUM_A_REG; i++) begin
            if (d_map[i] == frl.rw_addr) begin
                rw_mapped = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            for (int i = 0; i < `NUM_A_REG; i++) begin
                d_map[i] <= d_addr_t'(i);
            end
            s_map <= '0;
        end else if (accept) begin
            if (dec.use_rw) begin
                d_map[dec.arch_rw] <= frl.rw_addr;
            end
            if (dec.use_rs) begin
                s_map <= frl.rs_addr;
            end
        end
    end

    // Free list must never hand out a register that is still mapped.
    a_rw_unique: assert property (@(posedge clk) disable iff (!n_rst)
        accept && dec.use_rw |-> !rw_mapped);
    a_rs_unique: assert property (@(posedge clk) disable iff (!n_rst)
        accept && dec.use_rs |-> frl.rs_addr != s_map);

endmodule

// File: free_reg_list.sv
`timescale 1ns/1ps
`include "rename_cfg.svh"

module free_reg_list
    import rename_pkg::*;
(
    input  logic            clk,
    input  logic            n_rst,
    decoder_ifc.in          dec,
    reorder_buffer_ifc.in   commit,
    input  logic            rob_full,
    free_reg_list_ifc.out   frl_out
);

    reg_state_t d_state [`NUM_D_REG];
    reg_state_t s_state [`NUM_S_REG];

    logic    d_found;
    d_addr_t d_lowest;
    logic    s_found;
    s_addr_t s_lowest;

    logic need_rw, need_rs;
    logic checkin_rw, checkin_rs;
    logic checkout_rw, checkout_rs;
    logic rw_available, rs_available;
    logic stall;

    // Lowest idle register of each class.
    always_comb begin
        d_found  = 1'b0;
        d_lowest = '0;
        for (int i = 0; i < `NUM_D_REG; i++) begin
            if (!d_found && d_state[i] == REG_IDLE) begin
                d_found  = 1'b1;
                d_lowest = d_addr_t'(i);
            end
        end
        s_found  = 1'b0;
        s_lowest = '0;
        for (int i = 0; i < `NUM_S_REG; i++) begin
            if (!s_found && s_state[i] == REG_IDLE) begin
                s_found  = 1'b1;
                s_lowest = s_addr_t'(i);
            end
        end
    end

    assign need_rw    = dec.valid & dec.use_rw;
    assign need_rs    = dec.valid & dec.use_rs;
    assign checkin_rw = commit.valid & commit.use_rw;
    assign checkin_rs = commit.valid & commit.use_rs;

    // A committing register is passed straight to the new instruction.
    assign rw_available = checkin_rw | d_found;
    assign rs_available = checkin_rs | s_found;

    assign frl_out.rw_addr = checkin_rw ? commit.prev_rw_addr : d_lowest;
    assign frl_out.rs_addr = checkin_rs ? commit.prev_rs_addr : s_lowest;

    assign stall = (need_rw & ~rw_available) | (need_rs & ~rs_available) |
                   (dec.valid & rob_full & ~commit.valid);
    assign frl_out.stall = stall;

    assign checkout_rw = need_rw & ~stall;
    assign checkout_rs = need_rs & ~stall;

    // Initial architectural mapping starts busy.
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            for (int i = 0; i < `NUM_D_REG; i++) begin
                d_state[i] <= (i < `NUM_A_REG) ? REG_BUSY : REG_IDLE;
            end
            for (int i = 0; i < `NUM_S_REG; i++) begin
                s_state[i] <= (i == 0) ? REG_BUSY : REG_IDLE;
            end
        end else begin
            if (checkin_rw && !checkout_rw) begin
                d_state[commit.prev_rw_addr] <= REG_IDLE;
            end else if (checkout_rw && !checkin_rw) begin
                d_state[d_lowest] <= REG_BUSY;
            end
            if (checkin_rs && !checkout_rs) begin
                s_state[commit.prev_rs_addr] <= REG_IDLE;
            end else if (checkout_rs && !checkin_rs) begin
                s_state[s_lowest] <= REG_BUSY;
            end
        end
    end

    a_checkin_busy: assert property (@(posedge clk) disable iff (!n_rst)
        (checkin_rw |-> d_state[commit.prev_rw_addr] == REG_BUSY) and
        (checkin_rs |-> s_state[commit.prev_rs_addr] == REG_BUSY));
    a_checkout_avail: assert property (@(posedge clk) disable iff (!n_rst)
        (checkout_rw && !checkin_rw |-> d_state[frl_out.rw_addr] == REG_IDLE) and
        (checkout_rs && !checkin_rs |-> s_state[frl_out.rs_addr] == REG_IDLE));

endmodule

// File: reorder_buffer.sv
`timescale 1ns/1ps
`include "rename_cfg.svh"

module reorder_buffer
    import rename_pkg::*;
(
    input  logic            clk,
    input  logic            n_rst,
    decoder_ifc.in          dec,
    free_reg_list_ifc.in    frl,
    input  d_addr_t         prev_rw_addr,
    input  s_addr_t         prev_rs_addr,
    input  logic            retire,
    reorder_buffer_ifc.out  commit,
    output logic            rob_full,
    output d_addr_t         commit_rw_addr,
    output s_addr_t         commit_rs_addr
);

    localparam int PTR_W = $clog2(`ROB_DEPTH);
    localparam logic [PTR_W:0] DEPTH = `ROB_DEPTH;

    typedef struct packed {
        logic    use_rw;
        logic    use_rs;
        d_addr_t rw_addr;
        s_addr_t rs_addr;
        d_addr_t prev_rw_addr;
        s_addr_t prev_rs_addr;
    } rob_entry_t;

    rob_entry_t entries [`ROB_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;

    logic empty;
    logic push;
    logic pop;

    assign empty    = (count == '0);
    assign rob_full = (count == DEPTH);
    assign push     = dec.valid & ~frl.stall;
    assign pop      = retire & ~empty;

    // Head entry is presented while a retire strobe is seen.
    assign commit.valid        = pop;
    assign commit.use_rw       = entries[head].use_rw;
    assign commit.use_rs       = entries[head].use_rs;
    assign commit.prev_rw_addr = entries[head].prev_rw_addr;
    assign commit.prev_rs_addr = entries[head].prev_rs_addr;
    assign commit_rw_addr      = entries[head].rw_addr;
    assign commit_rs_addr      = entries[head].rs_addr;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail] <= '{use_rw:       dec.use_rw,
                               use_rs:       dec.use_rs,
                               rw_addr:      frl.rw_addr,
                               rs_addr:      frl.rs_addr,
                               prev_rw_addr: prev_rw_addr,
                               prev_rs_addr: prev_rs_addr};
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= tail + 1'b1;
            if (pop)  head <= head + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!n_rst)
        count <= DEPTH);

endmodule

// File: rename_top.sv
`timescale 1ns/1ps

module rename_top
    import rename_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       instr_valid,
    input  logic [7:0] instr,
    input  logic       retire,
    output logic       stall,
    output d_addr_t    rename_rw_addr,
    output s_addr_t    rename_rs_addr,
    output d_addr_t    rename_prev_rw_addr,
    output s_addr_t    rename_prev_rs_addr,
    output logic       commit_valid,
    output d_addr_t    commit_rw_addr,
    output s_addr_t    commit_rs_addr
);

    decoder_ifc        dec_if ();
    free_reg_list_ifc  frl_if ();
    reorder_buffer_ifc rob_if ();

    logic rob_full;

    instr_decoder u_decoder (
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec         (dec_if.out)
    );

    rename_map u_map (
        .clk          (clk),
        .n_rst        (n_rst),
        .dec          (dec_if.in),
        .frl          (frl_if.in),
        .prev_rw_addr (rename_prev_rw_addr),
        .prev_rs_addr (rename_prev_rs_addr)
    );

    free_reg_list u_free_list (
        .clk      (clk),
        .n_rst    (n_rst),
        .dec      (dec_if.in),
        .commit   (rob_if.in),
        .rob_full (rob_full),
        .frl_out  (frl_if.out)
    );

    reorder_buffer u_rob (
        .clk            (clk),
        .n_rst          (n_rst),
        .dec            (dec_if.in),
        .frl            (frl_if.in),
        .prev_rw_addr   (rename_prev_rw_addr),
        .prev_rs_addr   (rename_prev_rs_addr),
        .retire         (retire),
        .commit         (rob_if.out),
        .rob_full       (rob_full),
        .commit_rw_addr (commit_rw_addr),
        .commit_rs_addr (commit_rs_addr)
    );

    assign stall          = frl_if.stall;
    assign rename_rw_addr = frl_if.rw_addr;
    assign rename_rs_addr = frl_if.rs_addr;
    assign commit_valid   = rob_if.valid;

endmodule

// File: tb_rename.sv
`timescale 1ns/1ps
`include "rename_cfg.svh"

module tb_rename
    import rename_pkg::*;
();

    localparam int N_RANDOM   = 400;
    localparam int RUN_CYCLES = 10 + 100 + N_RANDOM;

    typedef struct packed {
        logic    use_rw;
        logic    use_rs;
        d_addr_t rw;
        s_addr_t rs;
        d_addr_t prev_rw;
        s_addr_t prev_rs;
    } model_entry_t;

    logic       clk, n_rst, instr_valid, retire, stall, commit_valid, took;
    logic [7:0] instr;
    d_addr_t    rename_rw_addr, rename_prev_rw_addr, commit_rw_addr;
    s_addr_t    rename_rs_addr, rename_prev_rs_addr, commit_rs_addr;

    // Reference model state.
    logic [`NUM_D_REG-1:0] d_idle;
    logic [`NUM_S_REG-1:0] s_idle;
    d_addr_t               amap [`NUM_A_REG];
    s_addr_t               smap;
    model_entry_t          model_q [$];
    model_entry_t          q_head, ent;
    int                    q_count, low_d, low_s;
    logic                  need_rw, need_rs, reuse_rw, reuse_rs, exp_stall, exp_commit;
    d_addr_t               exp_rw;
    s_addr_t               exp_rs;
    integer                seed = 30526;

    rename_top UUT (.*);

    function automatic int lowest_idle(input logic [`NUM_D_REG-1:0] idle);
        for (int i = 0; i < `NUM_D_REG; i++) begin
            if (idle[i]) return i;
        end
        return -1;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        $display("=== FAIL ===");
        $fatal(1, "Mismatch on %s", name);
    endtask

    // Holds the instruction until the DUT takes it.
    task automatic send(input logic [7:0] word, input logic ret);
        instr_valid = 1'b1;
        instr       = word;
        retire      = ret;
        @(negedge clk);
        while (!took) begin
            @(negedge clk);
        end
        instr_valid = 1'b0;
        retire      = 1'b0;
    endtask

    task automatic hold(input logic [7:0] word, input int cycles);
        instr_valid = 1'b1;
        instr       = word;
        repeat (cycles) @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic retire_only(input int cycles);
        retire = 1'b1;
        repeat (cycles) @(negedge clk);
        retire = 1'b0;
    endtask

    // Expected responses for the current inputs.
    always_comb begin
        need_rw    = instr_valid && (instr[7:6] == OP_MOV || instr[7:6] == OP_NAND);
        need_rs    = instr_valid && (instr[7:6] == OP_CMP || instr[7:6] == OP_NAND);
        exp_commit = retire && q_count > 0;
        reuse_rw   = exp_commit && q_head.use_rw;
        reuse_rs   = exp_commit && q_head.use_rs;
        low_d      = lowest_idle(d_idle);
        low_s      = lowest_idle({{(`NUM_D_REG-`NUM_S_REG){1'b0}}, s_idle});
        exp_rw     = reuse_rw ? q_head.prev_rw : d_addr_t'(low_d);
        exp_rs     = reuse_rs ? q_head.prev_rs : s_addr_t'(low_s);
        exp_stall  = (need_rw && !reuse_rw && low_d < 0) || (need_rs && !reuse_rs && low_s < 0) ||
                     (instr_valid && q_count == `ROB_DEPTH && !exp_commit);
    end

    always @(posedge clk) begin
        if (!n_rst) begin
            d_idle = {{(`NUM_D_REG-`NUM_A_REG){1'b1}}, {`NUM_A_REG{1'b0}}};
            s_idle = {{(`NUM_S_REG-1){1'b1}}, 1'b0};
            foreach (amap[i]) amap[i] = d_addr_t'(i);
            smap = '0;
            model_q.delete();
        end else begin
            ent = '{need_rw, need_rs, exp_rw, exp_rs, amap[instr[5:3]], smap};
            if (exp_commit) begin
                if (q_head.use_rw) d_idle[q_head.prev_rw] = 1'b1;
                if (q_head.use_rs) s_idle[q_head.prev_rs] = 1'b1;
                void'(model_q.pop_front());
            end
            // A register freed by the commit above is taken again here.
            if (instr_valid && !exp_stall) begin
                if (need_rw) begin
                    d_idle[exp_rw]   = 1'b0;
                    amap[instr[5:3]] = exp_rw;
                end
                if (need_rs) begin
                    s_idle[exp_rs] = 1'b0;
                    smap           = exp_rs;
                end
                model_q.push_back(ent);
            end
        end
        q_count = model_q.size();
        q_head  = (q_count > 0) ? model_q[0] : '0;
    end

    always @(posedge clk) took <= instr_valid && !stall;

    a_stall: assert property (@(posedge clk) disable iff (!n_rst) stall == exp_stall)
        else report_mismatch("stall", $sampled(exp_stall), $sampled(stall));
    a_rw: assert property (@(posedge clk) disable iff (!n_rst)
        need_rw && !exp_stall |-> rename_rw_addr == exp_rw)
        else report_mismatch("rename_rw_addr", $sampled(exp_rw), $sampled(rename_rw_addr));
    a_rs: assert property (@(posedge clk) disable iff (!n_rst)
        need_rs && !exp_stall |-> rename_rs_addr == exp_rs)
        else report_mismatch("rename_rs_addr", $sampled(exp_rs), $sampled(rename_rs_addr));
    a_prev_rw: assert property (@(posedge clk) disable iff (!n_rst)
        need_rw |-> rename_prev_rw_addr == amap[instr[5:3]])
        else report_mismatch("rename_prev_rw_addr", $sampled(amap[instr[5:3]]),
                             $sampled(rename_prev_rw_addr));
    a_prev_rs: assert property (@(posedge clk) disable iff (!n_rst)
        need_rs |-> rename_prev_rs_addr == smap)
        else report_mismatch("rename_prev_rs_addr", $sampled(smap), $sampled(rename_prev_rs_addr));
    a_commit: assert property (@(posedge clk) disable iff (!n_rst) commit_valid == exp_commit)
        else report_mismatch("commit_valid", $sampled(exp_commit), $sampled(commit_valid));
    a_commit_rw: assert property (@(posedge clk) disable iff (!n_rst)
        exp_commit && q_head.use_rw |-> commit_rw_addr == q_head.rw)
        else report_mismatch("commit_rw_addr", $sampled(q_head.rw), $sampled(commit_rw_addr));
    a_commit_rs: assert property (@(posedge clk) disable iff (!n_rst)
        exp_commit && q_head.use_rs |-> commit_rs_addr == q_head.rs)
        else report_mismatch("commit_rs_addr", $sampled(q_head.rs), $sampled(commit_rs_addr));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * 40 + 2000);
        $display("Timeout: the stimulus did not complete within the expected run time");
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        n_rst       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        retire      = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        // Fill every idle data register and then every idle status register.
        for (int i = 0; i < `NUM_A_REG; i++) begin
            send({OP_MOV, 3'(i), 3'b000}, 1'b0);
        end
        hold({OP_MOV, 3'd5, 3'd0}, 4);
        repeat (3) send({OP_CMP, 6'd0}, 1'b0);
        hold({OP_CMP, 6'd0}, 3);
        send({OP_MOV, 3'd2, 3'd0}, 1'b1);
        retire_only(20);
        // Fill the reorder buffer with NOPs alone.
        repeat (`ROB_DEPTH) send(8'h00, 1'b0);
        hold(8'h00, 3);
        send(8'h00, 1'b1);
        retire_only(20);
        repeat (N_RANDOM) begin
            if (!instr_valid || took) begin
                instr_valid = ($random(seed) & 3) != 0;
                instr       = 8'($random(seed));
            end
            retire = 1'($random(seed) & 1);
            @(negedge clk);
        end
        instr_valid = 1'b0;
        retire      = 1'b0;
        repeat (2) @(negedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: list.f
+incdir+.
rename_pkg.sv
rename_ifc.sv
instr_decoder.sv
rename_map.sv
free_reg_list.sv
reorder_buffer.sv
rename_top.sv
tb_rename.sv
